// File: sources.f
+incdir+dv
source/memMapPkg.sv
source/regAccessIf.sv
source/cpuBusPort.sv
source/ramBank.sv
source/anticRegs.sv
source/gtiaRegs.sv
source/memMapTop.sv
dv/memMapTb.sv

// File: Bender.yml
package:
  name: mem_map

sources:
  - source/memMapPkg.sv
  - source/regAccessIf.sv
  - source/cpuBusPort.sv
  - source/ramBank.sv
  - source/anticRegs.sv
  - source/gtiaRegs.sv
  - source/memMapTop.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/memMapTb.sv

// File: dv/memMapModel.svh
/* Shadow model of the RAM and both register banks plus the LCG stimulus source,
   included inside the memory map testbench module */
`ifndef MEM_MAP_MODEL_SVH
`define MEM_MAP_MODEL_SVH

localparam int ramDepth = 2 ** memMapPkg::ramAddrBits;

memMapPkg::byteT shadowRam [ramDepth];
memMapPkg::byteT shadowAntic [memMapPkg::anticRegCount];
memMapPkg::byteT shadowGtia [memMapPkg::gtiaRegCount];

function automatic logic [31:0] lcgStep(inout logic [31:0] state);
  state = state * 32'd1664525 + 32'd1013904223;
  return state;
endfunction

function automatic bit inIoPage(memMapPkg::addrT a);
  return a[15:12] == 4'hD;  // D000-DFFF
endfunction

function automatic bit inAntic(memMapPkg::addrT a);
  return a[15:4] == memMapPkg::anticBase[15:4];
endfunction

function automatic bit inGtia(memMapPkg::addrT a);
  return a[15:5] == memMapPkg::gtiaBase[15:5];
endfunction

function automatic bit isWsync(memMapPkg::addrT a);
  return inAntic(a) && (a[3:0] == memMapPkg::wsyncOfs);
endfunction

function automatic bit isHitclr(memMapPkg::addrT a);
  return inGtia(a) && (a[4:0] == memMapPkg::hitclrOfs);
endfunction

function automatic void modelReset();
  for (int i = 0; i < memMapPkg::anticRegCount; i++) shadowAntic[i] = '0;
  for (int i = 0; i < memMapPkg::gtiaRegCount; i++) shadowGtia[i] = '0;
  shadowAntic[memMapPkg::dmactlOfs] = memMapPkg::dmactlRst;
  shadowAntic[memMapPkg::dlisthOfs] = memMapPkg::dlisthRst;
  shadowAntic[memMapPkg::chbaseOfs] = memMapPkg::chbaseRst;
  shadowGtia[memMapPkg::hposP0Ofs] = memMapPkg::hposP0Rst;
  shadowGtia[memMapPkg::colPf0Ofs] = memMapPkg::colPf0Rst;
  shadowGtia[memMapPkg::colPf1Ofs] = memMapPkg::colPf1Rst;
  shadowGtia[memMapPkg::colPf2Ofs] = memMapPkg::colPf2Rst;
  shadowGtia[memMapPkg::colPf3Ofs] = memMapPkg::colPf3Rst;
  shadowGtia[memMapPkg::colBkOfs] = memMapPkg::colBkRst;
endfunction

function automatic memMapPkg::byteT modelRead(memMapPkg::addrT a);
  if (!inIoPage(a)) return shadowRam[a[memMapPkg::ramAddrBits-1:0]];  // Aliased RAM
  if (inAntic(a)) return shadowAntic[a[3:0]];
  if (inGtia(a)) return shadowGtia[a[4:0]];
  return '0;
endfunction

function automatic void modelWrite(memMapPkg::addrT a, memMapPkg::byteT d);
  if (!inIoPage(a)) begin
    shadowRam[a[memMapPkg::ramAddrBits-1:0]] = d;
  end else if (inAntic(a)) begin
    // Strobe, counters, light pen and unused slots keep no CPU data
    if (!(a[3:0] inside {memMapPkg::wsyncOfs, memMapPkg::vcountOfs, memMapPkg::penhOfs,
                         memMapPkg::penvOfs, 4'h6, 4'h8})) shadowAntic[a[3:0]] = d;
  end else if (inGtia(a) && (a[4:0] != memMapPkg::hitclrOfs)) begin
    shadowGtia[a[4:0]] = d;
  end
endfunction

// Called before modelWrite in the same cycle, so a CPU write overrides it
function automatic void modelChip(memMapPkg::anticUpdT code, logic [15:0] ad,
                                  logic gen, logic [4:0] gi, memMapPkg::byteT gd);
  case (code)
    memMapPkg::updDlistLow: shadowAntic[memMapPkg::dlistlOfs] = ad[7:0];
    memMapPkg::updDlistBoth: begin
      shadowAntic[memMapPkg::dlistlOfs] = ad[7:0];
      shadowAntic[memMapPkg::dlisthOfs] = ad[15:8];
    end
    memMapPkg::updVcount: shadowAntic[memMapPkg::vcountOfs] = ad[7:0];
    memMapPkg::updPenh: shadowAntic[memMapPkg::penhOfs] = ad[7:0];
    memMapPkg::updPenv: shadowAntic[memMapPkg::penvOfs] = ad[7:0];
    memMapPkg::updNmist: shadowAntic[memMapPkg::nmistOfs] = ad[7:0];
    default: ;
  endcase
  if (gen) shadowGtia[gi] = gd;
endfunction

`endif

// File: dv/memMapTb.sv
/* Testbench for the memory map top level: drives CPU requests and chip-side
   updates, checks responses, handshake, strobes and outputs with assertions */
`timescale 1ns/10ps
`default_nettype none

module memMapTb;

  localparam int timeoutCycles = 2000;  // Sequences take roughly half of this

  logic Fclk;
  logic rstN;
  logic reqValid;
  logic reqReady;
  logic reqWrite;
  memMapPkg::addrT reqAddr;
  memMapPkg::byteT reqData;
  logic rspValid;
  logic rspReady;
  memMapPkg::byteT rspData;
  memMapPkg::anticUpdT anticUpd;
  logic [2*memMapPkg::dataW-1:0] anticUpdData;
  logic gtiaUpdEn;
  logic [memMapPkg::gtiaOfsW-1:0] gtiaUpdIdx;
  memMapPkg::byteT gtiaUpdData;
  memMapPkg::byteT dmactl, chactl, hscrol, vscrol, pmbase, chbase, nmien;
  memMapPkg::addrT dlistAddr;
  memMapPkg::byteT colPf0, colPf1, colPf2, colPf3, colBk, prior, gractl;
  logic wsyncStrobe;
  logic hitclrStrobe;

  int cycleCount = 0;
  int dataErrors = 0;
  int protoErrors = 0;
  logic [31:0] stimSeed = 32'd31163;
  logic [31:0] stallSeed = 32'd31163;
  logic [31:0] stallRand;
  bit stallEn = 1'b0;
  int stallLeft = 0;
  memMapPkg::byteT expRsp;
  logic expValid = 1'b0;
  logic wsyncExp = 1'b0;
  logic hitclrExp = 1'b0;
  logic accNow;
  logic [memMapPkg::ramAddrBits-1:0] writtenIdx [$];  // RAM bytes with known content
  logic [71:0] anticOutExp;
  logic [55:0] gtiaOutExp;

  `include "memMapModel.svh"

  memMapTop memMapTop_i (.*);

  initial begin
    Fclk = 1'b0;
    forever #2 Fclk = ~Fclk;
  end

  assign accNow = reqValid && reqReady;
  assign anticOutExp = {shadowAntic[memMapPkg::dmactlOfs], shadowAntic[memMapPkg::chactlOfs],
                        shadowAntic[memMapPkg::hscrolOfs], shadowAntic[memMapPkg::vscrolOfs],
                        shadowAntic[memMapPkg::pmbaseOfs], shadowAntic[memMapPkg::chbaseOfs],
                        shadowAntic[memMapPkg::nmienOfs], shadowAntic[memMapPkg::dlisthOfs],
                        shadowAntic[memMapPkg::dlistlOfs]};
  assign gtiaOutExp = {shadowGtia[memMapPkg::colPf0Ofs], shadowGtia[memMapPkg::colPf1Ofs],
                       shadowGtia[memMapPkg::colPf2Ofs], shadowGtia[memMapPkg::colPf3Ofs],
                       shadowGtia[memMapPkg::colBkOfs], shadowGtia[memMapPkg::priorOfs],
                       shadowGtia[memMapPkg::gractlOfs]};

  always @(posedge Fclk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the sequences did not finish within %0d cycles", timeoutCycles);
      $display("Summary: %0d data errors, %0d protocol errors", dataErrors, protoErrors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Model follows the bus at every edge, read value taken before this edge's updates
  always @(posedge Fclk) begin
    if (!rstN) begin
      modelReset();
      expValid <= 1'b0;
      wsyncExp <= 1'b0;
      hitclrExp <= 1'b0;
    end else begin
      if (accNow && !reqWrite) begin
        expRsp <= modelRead(reqAddr);
        expValid <= 1'b1;
      end else if (rspReady) begin
        expValid <= 1'b0;
      end
      wsyncExp <= accNow && reqWrite && isWsync(reqAddr);
      hitclrExp <= accNow && reqWrite && isHitclr(reqAddr);
      modelChip(anticUpd, anticUpdData, gtiaUpdEn, gtiaUpdIdx, gtiaUpdData);
      if (accNow && reqWrite) modelWrite(reqAddr, reqData);
    end
  end

  always @(posedge Fclk) begin
    #1;
    if (!stallEn) begin
      rspReady = 1'b1;
    end else if (stallLeft > 0) begin
      rspReady = 1'b0;
      stallLeft--;
    end else begin
      stallRand = lcgStep(stallSeed);
      rspReady = (stallRand[22:21] != 2'b00);
      if (!rspReady) stallLeft = int'(stallRand[25:24]);  // Stretch of 1 to 4 cycles
    end
  end

  rspDataA: assert property (@(posedge Fclk) disable iff (!rstN)
    rspValid && rspReady |-> rspData == expRsp)
    else begin
      dataErrors++;
      $display("error %0t rspData got %h expected %h", $time, $sampled(rspData),
               $sampled(expRsp));
    end

  rspValidA: assert property (@(posedge Fclk) disable iff (!rstN) rspValid == expValid)
    else begin
      protoErrors++;
      $display("error %0t rspValid got %b expected %b", $time, $sampled(rspValid),
               $sampled(expValid));
    end

  reqReadyA: assert property (@(posedge Fclk)
    rstN && $past(rstN) |-> reqReady == (!rspValid || rspReady))
    else begin
      protoErrors++;
      $display("reqReady does not follow rspValid and rspReady at %0t", $time);
    end

  rspHoldA: assert property (@(posedge Fclk) disable iff (!rstN)
    rspValid && !rspReady |=> rspValid && $stable(rspData))
    else begin
      protoErrors++;
      $display("Response changed while rspReady was low at %0t", $time);
    end

  resetA: assert property (@(posedge Fclk)
    (cycleCount > 0) && !rstN |-> !rspValid && !reqReady && !wsyncStrobe && !hitclrStrobe)
    else begin
      protoErrors++;
      $display("Handshake or strobe outputs are not low during reset at %0t", $time);
    end

  wsyncA: assert property (@(posedge Fclk) disable iff (!rstN) wsyncStrobe == wsyncExp)
    else begin
      protoErrors++;
      $display("error %0t wsyncStrobe got %b expected %b", $time, $sampled(wsyncStrobe),
               $sampled(wsyncExp));
    end

  hitclrA: assert property (@(posedge Fclk) disable iff (!rstN) hitclrStrobe == hitclrExp)
    else begin
      protoErrors++;
      $display("error %0t hitclrStrobe got %b expected %b", $time, $sampled(hitclrStrobe),
               $sampled(hitclrExp));
    end

  anticOutA: assert property (@(posedge Fclk) disable iff (!rstN)
    {dmactl, chactl, hscrol, vscrol, pmbase, chbase, nmien, dlistAddr} == anticOutExp)
    else begin
      dataErrors++;
      $display("error %0t ANTIC outputs got %h expected %h", $time,
               $sampled({dmactl, chactl, hscrol, vscrol, pmbase, chbase, nmien, dlistAddr}),
               $sampled(anticOutExp));
    end

  gtiaOutA: assert property (@(posedge Fclk) disable iff (!rstN)
    {colPf0, colPf1, colPf2, colPf3, colBk, prior, gractl} == gtiaOutExp)
    else begin
      dataErrors++;
      $display("error %0t GTIA outputs got %h expected %h", $time,
               $sampled({colPf0, colPf1, colPf2, colPf3, colBk, prior, gractl}),
               $sampled(gtiaOutExp));
    end

  // Called 1 ns after an edge, holds the request until an edge accepts it
  task automatic issue(input bit w, input memMapPkg::addrT a, input memMapPkg::byteT d);
    bit ready;
    reqValid = 1'b1;
    reqWrite = w;
    reqAddr = a;
    reqData = d;
    do begin
      #1;
      ready = reqReady;
      @(posedge Fclk);
      #1;
    end while (!ready);
    reqValid = 1'b0;
  endtask

  task automatic drain();
    while (rspValid) begin
      @(posedge Fclk);
      #1;
    end
  endtask

  task automatic readAntic();
    for (int i = 0; i < memMapPkg::anticRegCount; i++) begin
      issue(1'b0, memMapPkg::addrT'(memMapPkg::anticBase + i), 8'h00);
    end
  endtask

  function automatic memMapPkg::addrT outsideIo(memMapPkg::addrT a);
    if (inIoPage(a)) a[15:12] = 4'h3;
    return a;
  endfunction

  initial begin : stimulus
    logic [31:0] r;
    memMapPkg::addrT a;
    rstN = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqData = '0;
    rspReady = 1'b1;
    anticUpd = memMapPkg::updNone;
    anticUpdData = '0;
    gtiaUpdEn = 1'b0;
    gtiaUpdIdx = '0;
    gtiaUpdData = '0;
    repeat (3) @(posedge Fclk);
    #1;
    rstN = 1'b1;
    @(posedge Fclk);
    #1;

    issue(1'b0, memMapPkg::anticBase + memMapPkg::dmactlOfs, 8'h00);  // Reset values
    issue(1'b0, memMapPkg::anticBase + memMapPkg::dlisthOfs, 8'h00);
    issue(1'b0, memMapPkg::anticBase + memMapPkg::chbaseOfs, 8'h00);
    issue(1'b0, memMapPkg::gtiaBase + memMapPkg::hposP0Ofs, 8'h00);
    issue(1'b0, memMapPkg::gtiaBase + memMapPkg::colPf0Ofs, 8'h00);
    issue(1'b0, memMapPkg::gtiaBase + memMapPkg::colPf1Ofs, 8'h00);
    issue(1'b0, memMapPkg::gtiaBase + memMapPkg::colPf2Ofs, 8'h00);
    issue(1'b0, memMapPkg::gtiaBase + memMapPkg::colPf3Ofs, 8'h00);
    issue(1'b0, memMapPkg::gtiaBase + memMapPkg::colBkOfs, 8'h00);

    for (int i = 0; i < 300; i++) begin  // RAM with aliased reads
      r = lcgStep(stimSeed);
      a = outsideIo(r[31:16]);
      if (writtenIdx.size() == 0 || r[3]) begin
        issue(1'b1, a, r[15:8]);
        writtenIdx.push_back(a[memMapPkg::ramAddrBits-1:0]);
      end else begin
        a[memMapPkg::ramAddrBits-1:0] = writtenIdx[r[14:4] % writtenIdx.size()];
        issue(1'b0, a, 8'h00);
      end
    end

    for (int i = 0; i < memMapPkg::anticRegCount; i++) begin
      r = lcgStep(stimSeed);
      issue(1'b1, memMapPkg::addrT'(memMapPkg::anticBase + i), r[23:16]);
      issue(1'b0, memMapPkg::addrT'(memMapPkg::anticBase + i), 8'h00);
    end
    for (int i = 0; i < memMapPkg::gtiaRegCount; i++) begin
      r = lcgStep(stimSeed);
      issue(1'b1, memMapPkg::addrT'(memMapPkg::gtiaBase + i), r[23:16]);
      issue(1'b0, memMapPkg::addrT'(memMapPkg::gtiaBase + i), 8'h00);
    end
    issue(1'b1, memMapPkg::anticBase + memMapPkg::wsyncOfs, 8'h00);  // Strobes back to back
    issue(1'b1, memMapPkg::anticBase + memMapPkg::wsyncOfs, 8'h00);
    issue(1'b1, memMapPkg::gtiaBase + memMapPkg::hitclrOfs, 8'h00);
    issue(1'b1, memMapPkg::gtiaBase + memMapPkg::hitclrOfs, 8'h00);
    issue(1'b1, 16'hD200, 8'h5A);  // Unmapped D page
    issue(1'b0, 16'hD200, 8'h00);
    issue(1'b0, 16'hD410, 8'h00);
    issue(1'b0, 16'hD020, 8'h00);
    issue(1'b0, 16'hDFFF, 8'h00);

    for (int c = 1; c <= 6; c++) begin  // Each ANTIC chip-side update alone
      r = lcgStep(stimSeed);
      anticUpd = memMapPkg::anticUpdT'(c);
      anticUpdData = r[31:16];
      @(posedge Fclk);
      #1;
      anticUpd = memMapPkg::updNone;
      readAntic();
    end
    r = lcgStep(stimSeed);
    anticUpd = memMapPkg::updDlistBoth;  // CPU keeps DLISTL, update still loads DLISTH
    anticUpdData = r[31:16];
    issue(1'b1, memMapPkg::anticBase + memMapPkg::dlistlOfs, r[7:0]);
    anticUpd = memMapPkg::updNmist;
    issue(1'b1, memMapPkg::anticBase + memMapPkg::nmistOfs, r[15:8]);
    anticUpd = memMapPkg::updNone;
    readAntic();

    for (int i = 0; i < memMapPkg::gtiaRegCount; i++) begin
      if (i <= 20 || i == 31) begin
        r = lcgStep(stimSeed);
        gtiaUpdEn = 1'b1;
        gtiaUpdIdx = i[4:0];
        gtiaUpdData = r[23:16];
        @(posedge Fclk);
        #1;
        gtiaUpdEn = 1'b0;
        issue(1'b0, memMapPkg::addrT'(memMapPkg::gtiaBase + i), 8'h00);
      end
    end
    r = lcgStep(stimSeed);
    gtiaUpdEn = 1'b1;  // Same-cycle collision with a CPU write
    gtiaUpdIdx = 5'h05;
    gtiaUpdData = r[23:16];
    issue(1'b1, memMapPkg::gtiaBase + 16'h0005, r[15:8]);
    gtiaUpdEn = 1'b0;
    issue(1'b0, memMapPkg::gtiaBase + 16'h0005, 8'h00);

    stallEn = 1'b1;  // Back-pressure with a request mix
    for (int i = 0; i < 150; i++) begin
      r = lcgStep(stimSeed);
      case (r[1:0])
        2'd0: begin
          a = outsideIo(r[31:16]);
          a[memMapPkg::ramAddrBits-1:0] = writtenIdx[r[14:4] % writtenIdx.size()];
          issue(1'b0, a, 8'h00);
        end
        2'd1: issue(1'b0, memMapPkg::anticBase + r[11:8], 8'h00);
        2'd2: issue(1'b0, memMapPkg::gtiaBase + r[12:8], 8'h00);
        default: begin
          a = outsideIo(r[31:16]);
          issue(1'b1, a, r[15:8]);
          writtenIdx.push_back(a[memMapPkg::ramAddrBits-1:0]);
        end
      endcase
    end
    drain();
    stallEn = 1'b0;
    repeat (4) @(posedge Fclk);

    $display("Summary: %0d data errors, %0d protocol errors", dataErrors, protoErrors);
    if (dataErrors + protoErrors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/memMapTop.sv
/* Memory map top level: the CPU bus port in front of the RAM bank and the
   ANTIC and GTIA register banks, with plain request, response and chip ports */
`default_nettype none
`timescale 1ns/10ps

module memMapTop (
  input  logic                               Fclk,
  input  logic                               rstN,
  // CPU request and response
  input  logic                               reqValid,
  output logic                               reqReady,
  input  logic                               reqWrite,
  input  memMapPkg::addrT                    reqAddr,
  input  memMapPkg::byteT                    reqData,
  output logic                               rspValid,
  input  logic                               rspReady,
  output memMapPkg::byteT                    rspData,
  // Chip-side updates
  input  memMapPkg::anticUpdT                anticUpd,
  input  logic [2*memMapPkg::dataW-1:0]      anticUpdData,
  input  logic                               gtiaUpdEn,
  input  logic [memMapPkg::gtiaOfsW-1:0]     gtiaUpdIdx,
  input  memMapPkg::byteT                    gtiaUpdData,
  // ANTIC controls
  output memMapPkg::byteT                    dmactl,
  output memMapPkg::byteT                    chactl,
  output memMapPkg::byteT                    hscrol,
  output memMapPkg::byteT                    vscrol,
  output memMapPkg::byteT                    pmbase,
  output memMapPkg::byteT                    chbase,
  output memMapPkg::byteT                    nmien,
  output memMapPkg::addrT                    dlistAddr,
  output logic                               wsyncStrobe,
  // GTIA controls
  output memMapPkg::byteT                    colPf0,
  output memMapPkg::byteT                    colPf1,
  output memMapPkg::byteT                    colPf2,
  output memMapPkg::byteT                    colPf3,
  output memMapPkg::byteT                    colBk,
  output memMapPkg::byteT                    prior,
  output memMapPkg::byteT                    gractl,
  output logic                               hitclrStrobe
);

  regAccessIf ramIf ();
  regAccessIf anticIf ();
  regAccessIf gtiaIf ();

  cpuBusPort cpuBusPort_i (
    .Fclk     (Fclk),
    .rstN     (rstN),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .reqWrite (reqWrite),
    .reqAddr  (reqAddr),
    .reqData  (reqData),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rspData  (rspData),
    .ramIf    (ramIf.host),
    .anticIf  (anticIf.host),
    .gtiaIf   (gtiaIf.host)
  );

  ramBank ramBank_i (
    .Fclk (Fclk),
    .bus  (ramIf.target)
  );

  anticRegs anticRegs_i (
    .Fclk         (Fclk),
    .rstN         (rstN),
    .bus          (anticIf.target),
    .anticUpd     (anticUpd),
    .anticUpdData (anticUpdData),
    .dmactl       (dmactl),
    .chactl       (chactl),
    .hscrol       (hscrol),
    .vscrol       (vscrol),
    .pmbase       (pmbase),
    .chbase       (chbase),
    .nmien        (nmien),
    .dlistAddr    (dlistAddr),
    .wsyncStrobe  (wsyncStrobe)
  );

  gtiaRegs gtiaRegs_i (
    .Fclk         (Fclk),
    .rstN         (rstN),
    .bus          (gtiaIf.target),
    .gtiaUpdEn    (gtiaUpdEn),
    .gtiaUpdIdx   (gtiaUpdIdx),
    .gtiaUpdData  (gtiaUpdData),
    .colPf0       (colPf0),
    .colPf1       (colPf1),
    .colPf2       (colPf2),
    .colPf3       (colPf3),
    .colBk        (colBk),
    .prior        (prior),
    .gractl       (gractl),
    .hitclrStrobe (hitclrStrobe)
  );

endmodule

`default_nettype wire

// File: source/gtiaRegs.sv
/* GTIA register bank: 32 registers with CPU readback, chip-side collision
   and trigger updates with CPU priority, color outputs and the HITCLR strobe */
`default_nettype none
`timescale 1ns/10ps

module gtiaRegs (
  input  logic                           Fclk,
  input  logic                           rstN,
  regAccessIf.target                     bus,
  input  logic                           gtiaUpdEn,
  input  logic [memMapPkg::gtiaOfsW-1:0] gtiaUpdIdx,
  input  memMapPkg::byteT                gtiaUpdData,
  output memMapPkg::byteT                colPf0,
  output memMapPkg::byteT                colPf1,
  output memMapPkg::byteT                colPf2,
  output memMapPkg::byteT                colPf3,
  output memMapPkg::byteT                colBk,
  output memMapPkg::byteT                prior,
  output memMapPkg::byteT                gractl,
  output logic                           hitclrStrobe
);

  memMapPkg::byteT regFile [memMapPkg::gtiaRegCount];
  logic [memMapPkg::gtiaOfsW-1:0] ofs;
  logic [memMapPkg::gtiaRegCount-1:0] ofsHot;
  logic [memMapPkg::gtiaRegCount-1:0] updHot;
  logic cpuWr;

  assign ofs = bus.addr[memMapPkg::gtiaOfsW-1:0];
  assign cpuWr = bus.sel && bus.write;

  always_comb begin
    ofsHot = '0;
    ofsHot[ofs] = 1'b1;
    updHot = '0;
    updHot[gtiaUpdIdx] = gtiaUpdEn;
  end

  always_ff @(posedge Fclk) begin
    if (!rstN) begin
      for (int i = 0; i < memMapPkg::gtiaRegCount; i++) begin
        regFile[i] <= '0;
      end
      regFile[memMapPkg::hposP0Ofs] <= memMapPkg::hposP0Rst;
      regFile[memMapPkg::colPf0Ofs] <= memMapPkg::colPf0Rst;
      regFile[memMapPkg::colPf1Ofs] <= memMapPkg::colPf1Rst;
      regFile[memMapPkg::colPf2Ofs] <= memMapPkg::colPf2Rst;
      regFile[memMapPkg::colPf3Ofs] <= memMapPkg::colPf3Rst;
      regFile[memMapPkg::colBkOfs] <= memMapPkg::colBkRst;
      hitclrStrobe <= 1'b0;
    end else begin
      for (int i = 0; i < memMapPkg::gtiaRegCount; i++) begin
        if (cpuWr && ofsHot[i] && memMapPkg::gtiaCpuWrMask[i]) begin
          regFile[i] <= bus.wdata;  // CPU wins over a same-cycle update
        end else if (updHot[i] && memMapPkg::gtiaUpdMask[i]) begin
          regFile[i] <= gtiaUpdData;
        end
      end
      hitclrStrobe <= cpuWr && (ofs == memMapPkg::hitclrOfs);
    end
  end

  always_ff @(posedge Fclk) begin
    if (bus.sel && !bus.write) begin
      bus.rdata <= regFile[ofs];  // HITCLR slot is never written and reads 00
    end
  end

  assign colPf0 = regFile[memMapPkg::colPf0Ofs];
  assign colPf1 = regFile[memMapPkg::colPf1Ofs];
  assign colPf2 = regFile[memMapPkg::colPf2Ofs];
  assign colPf3 = regFile[memMapPkg::colPf3Ofs];
  assign colBk = regFile[memMapPkg::colBkOfs];
  assign prior = regFile[memMapPkg::priorOfs];
  assign gractl = regFile[memMapPkg::gractlOfs];

  gtiaUpdIdxA: assert property (@(posedge Fclk) disable iff (!rstN)
    gtiaUpdEn |-> memMapPkg::gtiaUpdMask[gtiaUpdIdx]);

endmodule

`default_nettype wire

// File: source/anticRegs.sv
/* ANTIC register bank: CPU writes and reads, chip-side updates with CPU
   priority on the same register, and the WSYNC strobe */
`default_nettype none
`timescale 1ns/10ps

module anticRegs (
  input  logic                               Fclk,
  input  logic                               rstN,
  regAccessIf.target                         bus,
  input  memMapPkg::anticUpdT                anticUpd,
  input  logic [2*memMapPkg::dataW-1:0]      anticUpdData,
  output memMapPkg::byteT                    dmactl,
  output memMapPkg::byteT                    chactl,
  output memMapPkg::byteT                    hscrol,
  output memMapPkg::byteT                    vscrol,
  output memMapPkg::byteT                    pmbase,
  output memMapPkg::byteT                    chbase,
  output memMapPkg::byteT                    nmien,
  output memMapPkg::addrT                    dlistAddr,
  output logic                               wsyncStrobe
);

  memMapPkg::byteT regFile [memMapPkg::anticRegCount];
  logic [memMapPkg::anticOfsW-1:0] ofs;
  logic [memMapPkg::anticRegCount-1:0] ofsHot;
  logic [memMapPkg::anticRegCount-1:0] cpuHit;
  logic [memMapPkg::anticRegCount-1:0] updHit;
  logic cpuWr;
  logic wsyncWr;

  assign ofs = bus.addr[memMapPkg::anticOfsW-1:0];
  assign cpuWr = bus.sel && bus.write;
  assign wsyncWr = cpuWr && (ofs == memMapPkg::wsyncOfs);

  always_comb begin
    ofsHot = '0;
    ofsHot[ofs] = 1'b1;
  end

  // WSYNC, the read-only counters and the unused slots never store a CPU write
  assign cpuHit = cpuWr ? (ofsHot & memMapPkg::anticCpuWrMask) : '0;

  always_comb begin
    updHit = '0;
    case (anticUpd)
      memMapPkg::updDlistLow: updHit[memMapPkg::dlistlOfs] = 1'b1;
      memMapPkg::updDlistBoth: begin
        updHit[memMapPkg::dlistlOfs] = 1'b1;  // Each byte loses only to its own CPU write
        updHit[memMapPkg::dlisthOfs] = 1'b1;
      end
      memMapPkg::updVcount: updHit[memMapPkg::vcountOfs] = 1'b1;
      memMapPkg::updPenh: updHit[memMapPkg::penhOfs] = 1'b1;
      memMapPkg::updPenv: updHit[memMapPkg::penvOfs] = 1'b1;
      memMapPkg::updNmist: updHit[memMapPkg::nmistOfs] = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge Fclk) begin
    if (!rstN) begin
      for (int i = 0; i < memMapPkg::anticRegCount; i++) begin
        regFile[i] <= '0;
      end
      regFile[memMapPkg::dmactlOfs] <= memMapPkg::dmactlRst;
      regFile[memMapPkg::dlisthOfs] <= memMapPkg::dlisthRst;
      regFile[memMapPkg::chbaseOfs] <= memMapPkg::chbaseRst;
      wsyncStrobe <= 1'b0;
    end else begin
      for (int i = 0; i < memMapPkg::anticRegCount; i++) begin
        if (cpuHit[i]) begin
          regFile[i] <= bus.wdata;
        end else if (updHit[i]) begin
          regFile[i] <= (i == memMapPkg::dlisthOfs) ? anticUpdData[15:8] : anticUpdData[7:0];
        end
      end
      wsyncStrobe <= wsyncWr;
    end
  end

  // Slots 6, 8 and A stay at zero, so they read 00 without a mask
  always_ff @(posedge Fclk) begin
    if (bus.sel && !bus.write) begin
      bus.rdata <= regFile[ofs];
    end
  end

  assign dmactl = regFile[memMapPkg::dmactlOfs];
  assign chactl = regFile[memMapPkg::chactlOfs];
  assign hscrol = regFile[memMapPkg::hscrolOfs];
  assign vscrol = regFile[memMapPkg::vscrolOfs];
  assign pmbase = regFile[memMapPkg::pmbaseOfs];
  assign chbase = regFile[memMapPkg::chbaseOfs];
  assign nmien = regFile[memMapPkg::nmienOfs];
  assign dlistAddr = {regFile[memMapPkg::dlisthOfs], regFile[memMapPkg::dlistlOfs]};

  // Code 7 has no register and would be dropped silently
  anticUpdCodeA: assert property (@(posedge Fclk) disable iff (!rstN)
    !$isunknown(anticUpd) && (anticUpd <= memMapPkg::updNmist));

endmodule

`default_nettype wire

// File: source/ramBank.sv
/* Byte RAM behind the memory map, written on a selected write and read
   into a registered rdata one cycle after a selected read */
`default_nettype none
`timescale 1ns/10ps

module ramBank (
  input logic        Fclk,
  regAccessIf.target bus
);

  localparam int ramDepth = 2 ** memMapPkg::ramAddrBits;

  memMapPkg::byteT mem [ramDepth];
  logic [memMapPkg::ramAddrBits-1:0] ramIdx;

  assign ramIdx = bus.addr[memMapPkg::ramAddrBits-1:0];  // Aliases across the whole space

  always_ff @(posedge Fclk) begin
    if (bus.sel) begin
      if (bus.write) begin
        mem[ramIdx] <= bus.wdata;
      end else begin
        bus.rdata <= mem[ramIdx];
      end
    end
  end

  ramIdxKnownA: assert property (@(posedge Fclk)
    bus.sel |-> !$isunknown(ramIdx));

endmodule

`default_nettype wire

// File: source/cpuBusPort.sv
/* CPU side of the memory map: valid/ready request handshake, address decode
   to RAM, ANTIC or GTIA, and the one-cycle read response with back-pressure */
`default_nettype none
`timescale 1ns/10ps

module cpuBusPort (
  input  logic            Fclk,
  input  logic            rstN,
  input  logic            reqValid,
  output logic            reqReady,
  input  logic            reqWrite,
  input  memMapPkg::addrT reqAddr,
  input  memMapPkg::byteT reqData,
  output logic            rspValid,
  input  logic            rspReady,
  output memMapPkg::byteT rspData,
  regAccessIf.host        ramIf,
  regAccessIf.host        anticIf,
  regAccessIf.host        gtiaIf
);

  typedef enum logic [1:0] {tgtNone, tgtRam, tgtAntic, tgtGtia} tgtT;

  logic readyEn;  // Low in reset, high from the first cycle after
  logic accept;
  tgtT reqTgt;
  tgtT rspTgt;  // Target of the read in flight

  assign reqReady = readyEn && (!rspValid || rspReady);
  assign accept = reqValid && reqReady;

  always_comb begin
    if (reqAddr[memMapPkg::addrW-1 -: $bits(memMapPkg::ioPage)] != memMapPkg::ioPage) begin
      reqTgt = tgtRam;
    end else if (reqAddr[memMapPkg::addrW-1:memMapPkg::anticOfsW] ==
                 memMapPkg::anticBase[memMapPkg::addrW-1:memMapPkg::anticOfsW]) begin
      reqTgt = tgtAntic;
    end else if (reqAddr[memMapPkg::addrW-1:memMapPkg::gtiaOfsW] ==
                 memMapPkg::gtiaBase[memMapPkg::addrW-1:memMapPkg::gtiaOfsW]) begin
      reqTgt = tgtGtia;
    end else begin
      reqTgt = tgtNone;  // Rest of the D page
    end
  end

  assign ramIf.sel = accept && (reqTgt == tgtRam);
  assign ramIf.write = reqWrite;
  assign ramIf.addr = reqAddr;
  assign ramIf.wdata = reqData;

  assign anticIf.sel = accept && (reqTgt == tgtAntic);
  assign anticIf.write = reqWrite;
  assign anticIf.addr = reqAddr;
  assign anticIf.wdata = reqData;

  assign gtiaIf.sel = accept && (reqTgt == tgtGtia);
  assign gtiaIf.write = reqWrite;
  assign gtiaIf.addr = reqAddr;
  assign gtiaIf.wdata = reqData;

  always_ff @(posedge Fclk) begin
    if (!rstN) begin
      readyEn <= 1'b0;
      rspValid <= 1'b0;
      rspTgt <= tgtNone;
    end else begin
      readyEn <= 1'b1;
      if (accept && !reqWrite) begin  // Writes give no response
        rspValid <= 1'b1;
        rspTgt <= reqTgt;
      end else if (rspReady) begin
        rspValid <= 1'b0;
      end
    end
  end

  // Target rdata only moves on a new read, so the mux holds under back-pressure
  always_comb begin
    case (rspTgt)
      tgtRam: rspData = ramIf.rdata;
      tgtAntic: rspData = anticIf.rdata;
      tgtGtia: rspData = gtiaIf.rdata;
      default: rspData = '0;
    endcase
  end

  rspHoldA: assert property (@(posedge Fclk) disable iff (!rstN)
    rspValid && !rspReady |=> rspValid && $stable(rspData));

endmodule

`default_nettype wire

// File: source/regAccessIf.sv
/* Access channel from the CPU bus port to one memory map target */
`default_nettype none
`timescale 1ns/10ps

interface regAccessIf;

  logic sel;  // Request accepted this cycle
  logic write;
  memMapPkg::addrT addr;  // Full address, targets use only their low bits
  memMapPkg::byteT wdata;
  memMapPkg::byteT rdata;  // Registered, valid one cycle after a read sel

  modport host (
    output sel, write, addr, wdata,
    input rdata
  );

  modport target (
    input sel, write, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: source/memMapPkg.sv
/* Address map, widths, register offsets, reset values and chip-side update codes
   shared by the memory map blocks and the testbench through scoped names */
`default_nettype none

package memMapPkg;

  localparam int dataW = 8;
  localparam int addrW = 16;
  localparam int ramAddrBits = 12;  // RAM aliases modulo 2**ramAddrBits

  typedef logic [dataW-1:0] byteT;
  typedef logic [addrW-1:0] addrT;

  localparam logic [3:0] ioPage = 4'hD;  // D000-DFFF never reaches RAM
  localparam addrT anticBase = 16'hD400;
  localparam addrT gtiaBase = 16'hD000;
  localparam int anticRegCount = 16;
  localparam int gtiaRegCount = 32;
  localparam int anticOfsW = $clog2(anticRegCount);
  localparam int gtiaOfsW = $clog2(gtiaRegCount);

  // ANTIC offsets, 6 and 8 unused
  localparam logic [anticOfsW-1:0] dmactlOfs = 4'h0;
  localparam logic [anticOfsW-1:0] chactlOfs = 4'h1;
  localparam logic [anticOfsW-1:0] dlistlOfs = 4'h2;
  localparam logic [anticOfsW-1:0] dlisthOfs = 4'h3;
  localparam logic [anticOfsW-1:0] hscrolOfs = 4'h4;
  localparam logic [anticOfsW-1:0] vscrolOfs = 4'h5;
  localparam logic [anticOfsW-1:0] pmbaseOfs = 4'h7;
  localparam logic [anticOfsW-1:0] chbaseOfs = 4'h9;
  localparam logic [anticOfsW-1:0] wsyncOfs = 4'hA;
  localparam logic [anticOfsW-1:0] vcountOfs = 4'hB;
  localparam logic [anticOfsW-1:0] penhOfs = 4'hC;
  localparam logic [anticOfsW-1:0] penvOfs = 4'hD;
  localparam logic [anticOfsW-1:0] nmienOfs = 4'hE;
  localparam logic [anticOfsW-1:0] nmistOfs = 4'hF;

  // GTIA offsets
  localparam logic [gtiaOfsW-1:0] hposP0Ofs = 5'h00;
  localparam logic [gtiaOfsW-1:0] colPf0Ofs = 5'h16;
  localparam logic [gtiaOfsW-1:0] colPf1Ofs = 5'h17;
  localparam logic [gtiaOfsW-1:0] colPf2Ofs = 5'h18;
  localparam logic [gtiaOfsW-1:0] colPf3Ofs = 5'h19;
  localparam logic [gtiaOfsW-1:0] colBkOfs = 5'h1A;
  localparam logic [gtiaOfsW-1:0] priorOfs = 5'h1B;
  localparam logic [gtiaOfsW-1:0] gractlOfs = 5'h1D;
  localparam logic [gtiaOfsW-1:0] hitclrOfs = 5'h1E;

  localparam logic [anticRegCount-1:0] anticCpuWrMask = 16'hC2BF;  // Offsets the CPU stores into
  localparam logic [gtiaRegCount-1:0] gtiaCpuWrMask = 32'hBFFF_FFFF;  // All but HITCLR
  localparam logic [gtiaRegCount-1:0] gtiaUpdMask = 32'h801F_FFFF;  // 00-14 and 1F

  localparam byteT dmactlRst = 8'h02;
  localparam byteT dlisthRst = 8'hA0;
  localparam byteT chbaseRst = 8'hE0;
  localparam byteT colPf0Rst = 8'hD8;
  localparam byteT colPf1Rst = 8'h4C;
  localparam byteT colPf2Rst = 8'h40;
  localparam byteT colPf3Rst = 8'h1A;
  localparam byteT colBkRst = 8'h70;
  localparam byteT hposP0Rst = 8'h56;

  typedef enum logic [2:0] {
    updNone,
    updDlistLow,
    updDlistBoth,  // High byte of the update data goes to DLISTH
    updVcount,
    updPenh,
    updPenv,
    updNmist
  } anticUpdT;

endpackage

`default_nettype wire
